/* qkd_bob_defs.svh */
`ifndef QKD_BOB_DEFS_SVH
`define QKD_BOB_DEFS_SVH

// --------------------
// widths and depths
`define MSG_W        32     // message / er word
`define MSG_ADDR_W   11     // message ram, 2k words
`define EV_W         64     // ev random-bit word
`define EV_ADDR_W    6      // scaled-down ev ram
`define FIFO_DEPTH   16
`define FIFO_PTR_W   4

// --------------------
// message header
`define HDR_TYPE_MSB 31
`define HDR_TYPE_LSB 28
`define MSG_TYPE_ER  4'h1
`define MSG_TYPE_EV  4'h2
`define TX_MAX_WORDS 32     // payload cap per tx message

// --------------------
// start delay
`define START_SAT    255
`define START_FIRE   252
`define START_CNT_W  16

`endif

/* qkd_bob_pkg.sv */
`include "qkd_bob_defs.svh"

package qkd_bob_pkg;

    typedef logic [`MSG_W-1:0]      msg_word_t;  // message / er word
    typedef logic [`EV_W-1:0]       ev_word_t;   // two message words, low first
    typedef logic [`MSG_ADDR_W-1:0] msg_addr_t;
    typedef logic [`EV_ADDR_W-1:0]  ev_addr_t;
    typedef logic [`HDR_TYPE_MSB-`HDR_TYPE_LSB:0] msg_type_t;

    // receive parser
    typedef enum logic [2:0] {
        UP_IDLE,
        UP_RD_HDR,    // header read in flight
        UP_DISPATCH,  // header on ram output
        UP_ER_COPY,
        UP_EV_LO,
        UP_EV_HI,
        UP_DONE
    } unpack_state_t;

    // transmit builder
    typedef enum logic [1:0] {
        PK_IDLE,
        PK_HEADER,
        PK_DRAIN,
        PK_FINISH
    } pack_state_t;

endpackage

/* fifo_if.sv */
`timescale 1ns/1ps

interface fifo_if;

    // write side
    qkd_bob_pkg::msg_word_t din;
    logic                   wr_en;
    logic                   full;
    logic                   wr_ack;   // one cycle after an accepted write

    // read side, first word fall through
    logic                   rd_en;
    qkd_bob_pkg::msg_word_t dout;
    logic                   empty;
    logic                   valid;    // same cycle as the pop

    modport producer (
        output din, wr_en,
        input  full, wr_ack
    );

    modport fifo (
        input  din, wr_en, rd_en,
        output full, wr_ack, dout, empty, valid
    );

    modport consumer (
        output rd_en,
        input  dout, empty, valid
    );

endinterface

/* msg_ram.sv */
`timescale 1ns/1ps

module msg_ram #(
    parameter type word_t  = logic [31:0],
    parameter int  ADDR_W  = 11,
    parameter bit  OUT_REG = 1'b0    // extra read stage, ev ram only
) (
    input  logic              B_RX_EVrandombit_clkb,
    input  logic              rst_n,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  word_t             wdata,
    input  logic              re,
    input  logic [ADDR_W-1:0] raddr,
    output word_t             rdata
);

    word_t mem [2**ADDR_W];
    word_t rd_q;    // block ram read register

    always_ff @(posedge B_RX_EVrandombit_clkb) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rd_q <= mem[raddr];   // holds while re low
        end
    end

    generate
        if (OUT_REG) begin : g_out_reg
            word_t out_q;
            always_ff @(posedge B_RX_EVrandombit_clkb or negedge rst_n) begin
                if (!rst_n) begin
                    out_q <= '0;
                end else begin
                    out_q <= rd_q;  // free running delay stage
                end
            end
            assign rdata = out_q;
        end else begin : g_no_reg
            assign rdata = rd_q;
        end
    endgenerate

endmodule

/* er_fifo.sv */
`timescale 1ns/1ps

module er_fifo #(
    parameter int DEPTH_W = 4
) (
    input  logic B_RX_EVrandombit_clkb,
    input  logic rst_n,
    fifo_if.fifo f
);

    localparam int DEPTH = 2**DEPTH_W;

    qkd_bob_pkg::msg_word_t mem [DEPTH];
    logic [DEPTH_W-1:0] wr_ptr;
    logic [DEPTH_W-1:0] rd_ptr;
    logic [DEPTH_W:0]   count;    // one extra bit to tell full from empty
    logic               wr_ack_q;
    logic               push;
    logic               pop;

    assign push = f.wr_en && !f.full;    // writes into a full fifo are lost
    assign pop  = f.rd_en && !f.empty;

    // --------------------
    // storage, no reset
    always_ff @(posedge B_RX_EVrandombit_clkb) begin
        if (push) begin
            mem[wr_ptr] <= f.din;
        end
    end

    // --------------------
    // pointers and level
    always_ff @(posedge B_RX_EVrandombit_clkb or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            wr_ack_q <= 1'b0;
        end else begin
            wr_ack_q <= push;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    assign f.full   = (count == (DEPTH_W+1)'(DEPTH));
    assign f.empty  = (count == '0);
    assign f.dout   = mem[rd_ptr];    // head word shows without a read
    assign f.valid  = pop;
    assign f.wr_ack = wr_ack_q;

endmodule

/* start_delay.sv */
`timescale 1ns/1ps
`include "qkd_bob_defs.svh"

module start_delay (
    input  logic B_RX_EVrandombit_clkb,
    input  logic rst_n,
    input  logic start_switch,
    output logic start_er
);

    logic [`START_CNT_W-1:0] cnt;

    always_ff @(posedge B_RX_EVrandombit_clkb or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (start_switch && cnt != `START_CNT_W'(`START_SAT)) begin
            cnt <= cnt + 1'b1;   // stops for good at the saturation value
        end
    end

    // count passes the fire value only once
    assign start_er = (cnt == `START_CNT_W'(`START_FIRE));

endmodule

/* bob_unpacket.sv */
`timescale 1ns/1ps
`include "qkd_bob_defs.svh"

module bob_unpacket (
    input  logic                   B_RX_EVrandombit_clkb,
    input  logic                   rst_n,
    input  logic                   busy_net2pp_rx,
    input  logic                   msg_accessed,
    input  qkd_bob_pkg::msg_addr_t size_rx_msg,
    input  logic                   reset_er_parameter,
    input  qkd_bob_pkg::msg_word_t ram_rdata,
    output logic                   busy_pp2net_rx,
    output logic                   evrandombit_full,
    output logic                   ram_re,
    output qkd_bob_pkg::msg_addr_t ram_raddr,
    output logic                   ev_we,
    output qkd_bob_pkg::ev_addr_t  ev_waddr,
    output qkd_bob_pkg::ev_word_t  ev_wdata,
    fifo_if.producer               er
);

    qkd_bob_pkg::unpack_state_t state;
    qkd_bob_pkg::msg_addr_t     size_q;
    qkd_bob_pkg::msg_addr_t     rd_addr;   // word now on ram_rdata
    qkd_bob_pkg::msg_word_t     lo_q;      // low half of an ev pair
    qkd_bob_pkg::ev_addr_t      ev_addr;
    qkd_bob_pkg::msg_type_t     hdr_type;
    logic                       last_word;

    assign hdr_type  = ram_rdata[`HDR_TYPE_MSB:`HDR_TYPE_LSB];
    assign last_word = (rd_addr == size_q - qkd_bob_pkg::msg_addr_t'(1));

    // --------------------
    // ram, fifo and ev strobes
    always_comb begin
        ram_re    = 1'b0;
        ram_raddr = rd_addr + 1'b1;   // prefetch next word
        er.wr_en  = 1'b0;
        er.din    = ram_rdata;
        ev_we     = 1'b0;
        ev_waddr  = ev_addr;
        ev_wdata  = {ram_rdata, lo_q};
        case (state)
            qkd_bob_pkg::UP_RD_HDR: begin
                ram_re    = 1'b1;
                ram_raddr = rd_addr;
            end
            qkd_bob_pkg::UP_DISPATCH, qkd_bob_pkg::UP_EV_LO: begin
                ram_re = 1'b1;
            end
            qkd_bob_pkg::UP_ER_COPY: begin
                ram_re   = !er.full;  // ram output holds during the stall
                er.wr_en = !er.full;
            end
            qkd_bob_pkg::UP_EV_HI: begin
                ram_re = 1'b1;
                ev_we  = !evrandombit_full;
            end
            default: ;
        endcase
    end

    always_ff @(posedge B_RX_EVrandombit_clkb) begin
        if (state == qkd_bob_pkg::UP_EV_LO) begin
            lo_q <= ram_rdata;
        end
    end

    // --------------------
    // parser fsm
    always_ff @(posedge B_RX_EVrandombit_clkb or negedge rst_n) begin
        if (!rst_n) begin
            state            <= qkd_bob_pkg::UP_IDLE;
            busy_pp2net_rx   <= 1'b0;
            evrandombit_full <= 1'b0;
            ev_addr          <= '0;
            rd_addr          <= '0;
            size_q           <= '0;
        end else begin
            // ev address runs across messages
            if (reset_er_parameter) begin
                ev_addr          <= '0;
                evrandombit_full <= 1'b0;
            end else if (ev_we) begin
                ev_addr <= ev_addr + 1'b1;
                if (&ev_addr) begin
                    evrandombit_full <= 1'b1;   // 64th word written
                end
            end

            case (state)
                qkd_bob_pkg::UP_IDLE: begin
                    if (msg_accessed && !busy_net2pp_rx) begin
                        size_q         <= size_rx_msg;
                        rd_addr        <= '0;
                        busy_pp2net_rx <= 1'b1;
                        state          <= qkd_bob_pkg::UP_RD_HDR;
                    end
                end
                qkd_bob_pkg::UP_RD_HDR: state <= qkd_bob_pkg::UP_DISPATCH;
                qkd_bob_pkg::UP_DISPATCH: begin
                    rd_addr <= rd_addr + 1'b1;
                    if (size_q <= qkd_bob_pkg::msg_addr_t'(1)) begin
                        state <= qkd_bob_pkg::UP_DONE;   // header only
                    end else begin
                        case (hdr_type)
                            `MSG_TYPE_ER: state <= qkd_bob_pkg::UP_ER_COPY;
                            `MSG_TYPE_EV: state <= qkd_bob_pkg::UP_EV_LO;
                            default:      state <= qkd_bob_pkg::UP_DONE;
                        endcase
                    end
                end
                qkd_bob_pkg::UP_ER_COPY: begin
                    if (!er.full) begin
                        rd_addr <= rd_addr + 1'b1;
                        if (last_word) begin
                            state <= qkd_bob_pkg::UP_DONE;
                        end
                    end
                end
                qkd_bob_pkg::UP_EV_LO: begin
                    rd_addr <= rd_addr + 1'b1;
                    // odd trailing word is dropped
                    state <= last_word ? qkd_bob_pkg::UP_DONE : qkd_bob_pkg::UP_EV_HI;
                end
                qkd_bob_pkg::UP_EV_HI: begin
                    rd_addr <= rd_addr + 1'b1;
                    state <= last_word ? qkd_bob_pkg::UP_DONE : qkd_bob_pkg::UP_EV_LO;
                end
                default: begin
                    busy_pp2net_rx <= 1'b0;  // message ram back to network
                    state          <= qkd_bob_pkg::UP_IDLE;
                end
            endcase
        end
    end

endmodule

/* bob_packet.sv */
`timescale 1ns/1ps
`include "qkd_bob_defs.svh"

module bob_packet (
    input  logic                   B_RX_EVrandombit_clkb,
    input  logic                   rst_n,
    input  logic                   busy_net2pp_tx,
    output logic                   busy_pp2net_tx,
    output logic                   msg_stored,
    output qkd_bob_pkg::msg_addr_t size_tx_msg,
    output logic                   ram_we,
    output qkd_bob_pkg::msg_addr_t ram_waddr,
    output qkd_bob_pkg::msg_word_t ram_wdata,
    fifo_if.consumer               er
);

    qkd_bob_pkg::pack_state_t state;
    qkd_bob_pkg::msg_addr_t   cnt;      // payload words popped
    logic                     at_max;

    assign at_max = (cnt == qkd_bob_pkg::msg_addr_t'(`TX_MAX_WORDS));

    // --------------------
    // pop and ram write
    always_comb begin
        er.rd_en  = (state == qkd_bob_pkg::PK_DRAIN) && !er.empty && !at_max;
        ram_we    = 1'b0;
        ram_waddr = cnt + 1'b1;   // payload behind the header
        ram_wdata = er.dout;
        case (state)
            qkd_bob_pkg::PK_HEADER: begin
                ram_we    = 1'b1;
                ram_waddr = '0;
                ram_wdata = {`MSG_TYPE_ER, {`HDR_TYPE_LSB{1'b0}}};
            end
            qkd_bob_pkg::PK_DRAIN: ram_we = er.valid;
            default: ;
        endcase
    end

    // --------------------
    // builder fsm
    always_ff @(posedge B_RX_EVrandombit_clkb or negedge rst_n) begin
        if (!rst_n) begin
            state          <= qkd_bob_pkg::PK_IDLE;
            cnt            <= '0;
            busy_pp2net_tx <= 1'b0;
            msg_stored     <= 1'b0;
            size_tx_msg    <= '0;
        end else begin
            msg_stored <= 1'b0;   // single cycle strobe
            case (state)
                qkd_bob_pkg::PK_IDLE: begin
                    // network still owns the tx ram while busy
                    if (!er.empty && !busy_net2pp_tx) begin
                        busy_pp2net_tx <= 1'b1;
                        cnt            <= '0;
                        state          <= qkd_bob_pkg::PK_HEADER;
                    end
                end
                qkd_bob_pkg::PK_HEADER: state <= qkd_bob_pkg::PK_DRAIN;
                qkd_bob_pkg::PK_DRAIN: begin
                    if (er.valid) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (er.empty || at_max) begin
                        state <= qkd_bob_pkg::PK_FINISH;
                    end
                end
                default: begin
                    size_tx_msg    <= cnt + 1'b1;   // header included
                    msg_stored     <= 1'b1;
                    busy_pp2net_tx <= 1'b0;
                    state          <= qkd_bob_pkg::PK_IDLE;
                end
            endcase
        end
    end

endmodule

/* qkd_bob_top.sv */
`timescale 1ns/1ps
`include "qkd_bob_defs.svh"

module qkd_bob_top (
    input  logic                   B_RX_EVrandombit_clkb,
    input  logic                   rst_n,
    input  logic                   start_switch,
    output logic                   start_er,
    input  logic                   busy_net2pp_rx,
    input  logic                   msg_accessed,
    input  qkd_bob_pkg::msg_addr_t size_rx_msg,
    input  logic                   rx_msg_we,
    input  qkd_bob_pkg::msg_addr_t rx_msg_addr,
    input  qkd_bob_pkg::msg_word_t rx_msg_data,
    output logic                   busy_pp2net_rx,
    input  logic                   reset_er_parameter,
    output logic                   evrandombit_full,
    input  logic                   evrandombit_en,
    input  qkd_bob_pkg::ev_addr_t  evrandombit_addr,
    output qkd_bob_pkg::ev_word_t  evrandombit_dout,
    input  logic                   rx_er_rd_en,
    output qkd_bob_pkg::msg_word_t rx_er_dout,
    output logic                   rx_er_empty,
    output logic                   rx_er_valid,
    input  qkd_bob_pkg::msg_word_t tx_er_din,
    input  logic                   tx_er_wr_en,
    output logic                   tx_er_full,
    output logic                   tx_er_wr_ack,
    input  logic                   busy_net2pp_tx,
    output logic                   busy_pp2net_tx,
    output logic                   msg_stored,
    output qkd_bob_pkg::msg_addr_t size_tx_msg,
    input  qkd_bob_pkg::msg_addr_t tx_msg_addr,
    output qkd_bob_pkg::msg_word_t tx_msg_data
);

    logic                   rx_ram_re;
    qkd_bob_pkg::msg_addr_t rx_ram_raddr;
    qkd_bob_pkg::msg_word_t rx_ram_rdata;
    logic                   ev_we;
    qkd_bob_pkg::ev_addr_t  ev_waddr;
    qkd_bob_pkg::ev_word_t  ev_wdata;
    logic                   tx_ram_we;
    qkd_bob_pkg::msg_addr_t tx_ram_waddr;
    qkd_bob_pkg::msg_word_t tx_ram_wdata;

    fifo_if rx_er ();   // a2b, unpacker to er core
    fifo_if tx_er ();   // b2a, er core to packer

    // er core side of both fifos
    assign rx_er.rd_en  = rx_er_rd_en;
    assign rx_er_dout   = rx_er.dout;
    assign rx_er_empty  = rx_er.empty;
    assign rx_er_valid  = rx_er.valid;
    assign tx_er.din    = tx_er_din;
    assign tx_er.wr_en  = tx_er_wr_en;
    assign tx_er_full   = tx_er.full;
    assign tx_er_wr_ack = tx_er.wr_ack;

    start_delay u_start (.B_RX_EVrandombit_clkb, .rst_n, .start_switch, .start_er);

    // --------------------
    // receive path
    msg_ram #(.word_t(qkd_bob_pkg::msg_word_t), .ADDR_W(`MSG_ADDR_W), .OUT_REG(1'b0)) u_rx_ram (
        .B_RX_EVrandombit_clkb, .rst_n,
        .we(rx_msg_we), .waddr(rx_msg_addr), .wdata(rx_msg_data),
        .re(rx_ram_re), .raddr(rx_ram_raddr), .rdata(rx_ram_rdata)
    );

    bob_unpacket u_unpack (
        .B_RX_EVrandombit_clkb, .rst_n,
        .busy_net2pp_rx, .msg_accessed, .size_rx_msg, .reset_er_parameter,
        .ram_rdata(rx_ram_rdata),
        .busy_pp2net_rx, .evrandombit_full,
        .ram_re(rx_ram_re), .ram_raddr(rx_ram_raddr),
        .ev_we, .ev_waddr, .ev_wdata,
        .er(rx_er.producer)
    );

    er_fifo #(.DEPTH_W(`FIFO_PTR_W)) u_rx_fifo (.B_RX_EVrandombit_clkb, .rst_n, .f(rx_er.fifo));

    // ev ram, two cycle read
    msg_ram #(.word_t(qkd_bob_pkg::ev_word_t), .ADDR_W(`EV_ADDR_W), .OUT_REG(1'b1)) u_ev_ram (
        .B_RX_EVrandombit_clkb, .rst_n,
        .we(ev_we), .waddr(ev_waddr), .wdata(ev_wdata),
        .re(evrandombit_en), .raddr(evrandombit_addr), .rdata(evrandombit_dout)
    );

    // --------------------
    // transmit path
    er_fifo #(.DEPTH_W(`FIFO_PTR_W)) u_tx_fifo (.B_RX_EVrandombit_clkb, .rst_n, .f(tx_er.fifo));

    bob_packet u_pack (
        .B_RX_EVrandombit_clkb, .rst_n, .busy_net2pp_tx,
        .busy_pp2net_tx, .msg_stored, .size_tx_msg,
        .ram_we(tx_ram_we), .ram_waddr(tx_ram_waddr), .ram_wdata(tx_ram_wdata),
        .er(tx_er.consumer)
    );

    msg_ram #(.word_t(qkd_bob_pkg::msg_word_t), .ADDR_W(`MSG_ADDR_W), .OUT_REG(1'b0)) u_tx_ram (
        .B_RX_EVrandombit_clkb, .rst_n,
        .we(tx_ram_we), .waddr(tx_ram_waddr), .wdata(tx_ram_wdata),
        .re(1'b1), .raddr(tx_msg_addr), .rdata(tx_msg_data)   // network side always reads
    );

endmodule

/* tb_qkd_bob.sv */
`timescale 1ns/1ps
`include "qkd_bob_defs.svh"

module tb_qkd_bob;

    localparam int TIMEOUT = 500;    // cycles allowed per wait

    logic B_RX_EVrandombit_clkb;
    logic rst_n;
    logic start_switch, start_er;
    logic busy_net2pp_rx, msg_accessed, busy_pp2net_rx;
    logic rx_msg_we, reset_er_parameter, evrandombit_full, evrandombit_en;
    logic rx_er_rd_en, rx_er_empty, rx_er_valid;
    logic tx_er_wr_en, tx_er_full, tx_er_wr_ack;
    logic busy_net2pp_tx, busy_pp2net_tx, msg_stored;
    qkd_bob_pkg::msg_addr_t size_rx_msg, rx_msg_addr, size_tx_msg, tx_msg_addr;
    qkd_bob_pkg::msg_word_t rx_msg_data, rx_er_dout, tx_er_din, tx_msg_data;
    qkd_bob_pkg::ev_addr_t  evrandombit_addr;
    qkd_bob_pkg::ev_word_t  evrandombit_dout;

    logic [31:0]            lfsr;
    qkd_bob_pkg::msg_word_t payload [$];    // payload of the last rx message
    qkd_bob_pkg::msg_word_t rx_model [$];   // words expected out of the a2b fifo
    qkd_bob_pkg::ev_word_t  ev_model [64];
    int                     ev_wr;          // next ev address in the model
    int                     rx_popped;
    qkd_bob_pkg::ev_word_t  ev_shown;       // word left in the ev output register
    bit                     ev_shown_ok;    // set after the first ev read

    qkd_bob_top DUT (.*);

    always #4 B_RX_EVrandombit_clkb = ~B_RX_EVrandombit_clkb;   // 8 ns period

    // --------------------
    // stimulus and reference
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    function automatic qkd_bob_pkg::msg_word_t rand_word();
        qkd_bob_pkg::msg_word_t w;
        int i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit
            w    = {w[30:0], lfsr[31]};
        end
        return w;
    endfunction

    function automatic qkd_bob_pkg::ev_word_t ev_pack(input qkd_bob_pkg::msg_word_t lo,
                                                      input qkd_bob_pkg::msg_word_t hi);
        return {hi, lo};   // first word of the pair is the low half
    endfunction

    function automatic qkd_bob_pkg::msg_word_t tx_header();
        qkd_bob_pkg::msg_word_t h;
        h = '0;                                          // all other bits zero
        h[`HDR_TYPE_MSB:`HDR_TYPE_LSB] = `MSG_TYPE_ER;
        return h;
    endfunction

    function automatic int tx_size(input int n_words);
        return n_words + 1;   // payload plus header
    endfunction

    // --------------------
    // checking
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            stop_run($sformatf("Fail at %0t: %s = 0x%0h, expected 0x%0h", $time, name, act, exp));
        end
    endtask

    // a2b fifo read side against the queue model
    always @(negedge B_RX_EVrandombit_clkb) begin
        if (rst_n === 1'b1 && rx_er_valid === 1'b1) begin
            if (rx_model.size() == 0) begin
                stop_run("rx_er_valid came with no word left to expect");
            end else begin
                check("rx_er_dout", 64'(rx_er_dout), 64'(rx_model.pop_front()));
                rx_popped++;
            end
        end
    end

    task automatic wait_rx_done();
        int n;
        n = 0;
        @(negedge B_RX_EVrandombit_clkb);
        while (busy_pp2net_rx !== 1'b0) begin
            @(negedge B_RX_EVrandombit_clkb);
            n++;
            if (n > TIMEOUT) begin
                stop_run("busy_pp2net_rx never fell at the end of the unpack");
            end
        end
    endtask

    task automatic wait_msg_stored();
        int n;
        n = 0;
        @(negedge B_RX_EVrandombit_clkb);
        while (msg_stored !== 1'b1) begin
            @(negedge B_RX_EVrandombit_clkb);
            n++;
            if (n > TIMEOUT) begin
                stop_run("msg_stored never came after the transmit fifo was filled");
            end
        end
    endtask

    // header plus n_pay random words and the model update for its type
    task automatic send_rx_msg(input qkd_bob_pkg::msg_type_t typ, input int n_pay);
        qkd_bob_pkg::msg_word_t w;
        int k;
        payload.delete();
        @(posedge B_RX_EVrandombit_clkb);
        busy_net2pp_rx <= 1'b1;
        for (k = 0; k <= n_pay; k++) begin
            w = rand_word();
            if (k == 0) begin
                w[`HDR_TYPE_MSB:`HDR_TYPE_LSB] = typ;   // low header bits stay random
            end else begin
                payload.push_back(w);
            end
            @(posedge B_RX_EVrandombit_clkb);
            rx_msg_we   <= 1'b1;
            rx_msg_addr <= qkd_bob_pkg::msg_addr_t'(k);
            rx_msg_data <= w;
        end
        @(posedge B_RX_EVrandombit_clkb);
        rx_msg_we      <= 1'b0;
        busy_net2pp_rx <= 1'b0;
        size_rx_msg    <= qkd_bob_pkg::msg_addr_t'(n_pay + 1);
        msg_accessed   <= 1'b1;
        @(posedge B_RX_EVrandombit_clkb);
        msg_accessed   <= 1'b0;
        if (typ == `MSG_TYPE_ER) begin
            foreach (payload[j]) rx_model.push_back(payload[j]);
        end else if (typ == `MSG_TYPE_EV) begin
            for (k = 0; k + 1 < n_pay; k += 2) begin   // odd last word dropped
                if (ev_wr < 64) begin
                    ev_model[ev_wr] = ev_pack(payload[k], payload[k+1]);
                    ev_wr++;
                end
            end
        end
    endtask

    task automatic check_ev(input int a);
        @(posedge B_RX_EVrandombit_clkb);
        evrandombit_en   <= 1'b1;
        evrandombit_addr <= qkd_bob_pkg::ev_addr_t'(a);
        @(posedge B_RX_EVrandombit_clkb);
        evrandombit_en   <= 1'b0;
        @(negedge B_RX_EVrandombit_clkb);
        if (ev_shown_ok) begin
            // one cycle in, the output register still holds the last read
            check("evrandombit_dout after one cycle", evrandombit_dout, ev_shown);
        end
        @(posedge B_RX_EVrandombit_clkb);    // output register stage
        @(negedge B_RX_EVrandombit_clkb);
        check($sformatf("evrandombit_dout[%0d]", a), evrandombit_dout, ev_model[a]);
        ev_shown    = ev_model[a];
        ev_shown_ok = 1'b1;
    endtask

    task automatic check_tx(input int a, input qkd_bob_pkg::msg_word_t exp);
        @(posedge B_RX_EVrandombit_clkb);
        tx_msg_addr <= qkd_bob_pkg::msg_addr_t'(a);
        @(posedge B_RX_EVrandombit_clkb);
        @(negedge B_RX_EVrandombit_clkb);
        check($sformatf("tx_msg_data[%0d]", a), 64'(tx_msg_data), 64'(exp));
    endtask

    // --------------------
    // test sequence
    initial begin
        qkd_bob_pkg::msg_word_t tx_words [$];
        qkd_bob_pkg::msg_word_t w;
        int i;
        int n;
        B_RX_EVrandombit_clkb = 1'b0;
        rst_n = 1'b0;
        start_switch = 1'b0;
        busy_net2pp_rx = 1'b0;
        msg_accessed = 1'b0;
        size_rx_msg = '0;
        rx_msg_we = 1'b0;
        rx_msg_addr = '0;
        rx_msg_data = '0;
        reset_er_parameter = 1'b0;
        evrandombit_en = 1'b0;
        evrandombit_addr = '0;
        rx_er_rd_en = 1'b0;
        tx_er_din = '0;
        tx_er_wr_en = 1'b0;
        busy_net2pp_tx = 1'b0;
        tx_msg_addr = '0;
        lfsr = 32'h4711;
        ev_wr = 0;
        rx_popped = 0;
        ev_shown = '0;
        ev_shown_ok = 1'b0;
        repeat (8) @(posedge B_RX_EVrandombit_clkb);
        rst_n <= 1'b1;
        @(negedge B_RX_EVrandombit_clkb);
        check("start_er", 64'(start_er), 64'(0));
        check("busy_pp2net_rx", 64'(busy_pp2net_rx), 64'(0));
        check("busy_pp2net_tx", 64'(busy_pp2net_tx), 64'(0));
        check("msg_stored", 64'(msg_stored), 64'(0));
        check("evrandombit_full", 64'(evrandombit_full), 64'(0));
        check("rx_er_empty", 64'(rx_er_empty), 64'(1));
        check("tx_er_wr_ack", 64'(tx_er_wr_ack), 64'(0));
        check("tx_er_full", 64'(tx_er_full), 64'(0));

        // 1. one shot start pulse after 252 high cycles
        @(posedge B_RX_EVrandombit_clkb);
        start_switch <= 1'b1;
        for (i = 1; i <= 300; i++) begin
            @(posedge B_RX_EVrandombit_clkb);
            @(negedge B_RX_EVrandombit_clkb);
            check("start_er", 64'(start_er), 64'(i == `START_FIRE));
        end

        // 2. er routing with the fifo full and the unpacker stalled
        send_rx_msg(`MSG_TYPE_ER, 20);
        for (i = 0; i < 30; i++) begin
            @(negedge B_RX_EVrandombit_clkb);
            check("busy_pp2net_rx", 64'(busy_pp2net_rx), 64'(1));
        end
        check("rx_er_empty", 64'(rx_er_empty), 64'(0));
        @(posedge B_RX_EVrandombit_clkb);
        rx_er_rd_en <= 1'b1;
        n = 0;
        while (rx_popped < 20) begin
            @(posedge B_RX_EVrandombit_clkb);
            n++;
            if (n > TIMEOUT) begin
                stop_run("the a2b fifo never gave out all 20 er words");
            end
        end
        rx_er_rd_en <= 1'b0;
        wait_rx_done();
        check("rx_er_empty", 64'(rx_er_empty), 64'(1));

        // 3. ev packing and a message of unknown type
        send_rx_msg(`MSG_TYPE_EV, 8);
        wait_rx_done();
        for (i = 0; i < 4; i++) check_ev(i);
        send_rx_msg(4'h7, 6);
        wait_rx_done();
        check("rx_er_empty", 64'(rx_er_empty), 64'(1));
        check("evrandombit_full", 64'(evrandombit_full), 64'(0));
        for (i = 0; i < 4; i++) check_ev(i);

        // 4. ev full flag and its clear
        send_rx_msg(`MSG_TYPE_EV, 41);   // odd count drops the last word
        wait_rx_done();
        send_rx_msg(`MSG_TYPE_EV, 40);
        wait_rx_done();
        check("evrandombit_full", 64'(evrandombit_full), 64'(0));
        send_rx_msg(`MSG_TYPE_EV, 44);   // two pairs past the end
        wait_rx_done();
        check("evrandombit_full", 64'(evrandombit_full), 64'(ev_wr == 64));
        for (i = 0; i < 64; i++) check_ev(i);
        @(posedge B_RX_EVrandombit_clkb);
        reset_er_parameter <= 1'b1;
        @(posedge B_RX_EVrandombit_clkb);
        reset_er_parameter <= 1'b0;
        ev_wr = 0;
        @(negedge B_RX_EVrandombit_clkb);
        check("evrandombit_full", 64'(evrandombit_full), 64'(0));
        send_rx_msg(`MSG_TYPE_EV, 4);
        wait_rx_done();
        for (i = 0; i < 3; i++) check_ev(i);   // address 2 keeps the old word

        // 5. transmit held back by the network first
        @(posedge B_RX_EVrandombit_clkb);
        busy_net2pp_tx <= 1'b1;
        for (i = 0; i < 5; i++) begin
            w = rand_word();
            tx_words.push_back(w);
            @(posedge B_RX_EVrandombit_clkb);
            tx_er_din   <= w;
            tx_er_wr_en <= 1'b1;
            @(posedge B_RX_EVrandombit_clkb);
            tx_er_wr_en <= 1'b0;
            @(negedge B_RX_EVrandombit_clkb);
            check("tx_er_wr_ack", 64'(tx_er_wr_ack), 64'(1));
            check("tx_er_full", 64'(tx_er_full), 64'(tx_words.size() == `FIFO_DEPTH));
        end
        for (i = 0; i < 20; i++) begin
            @(negedge B_RX_EVrandombit_clkb);
            check("msg_stored", 64'(msg_stored), 64'(0));
            check("busy_pp2net_tx", 64'(busy_pp2net_tx), 64'(0));
        end
        @(posedge B_RX_EVrandombit_clkb);
        busy_net2pp_tx <= 1'b0;
        n = 0;
        @(negedge B_RX_EVrandombit_clkb);
        while (busy_pp2net_tx !== 1'b1) begin
            @(negedge B_RX_EVrandombit_clkb);
            n++;
            if (n > TIMEOUT) begin
                stop_run("busy_pp2net_tx never rose after the network released the tx ram");
            end
        end
        wait_msg_stored();
        check("size_tx_msg", 64'(size_tx_msg), 64'(tx_size(5)));
        check("busy_pp2net_tx", 64'(busy_pp2net_tx), 64'(0));   // drops with the strobe
        @(negedge B_RX_EVrandombit_clkb);
        check("msg_stored", 64'(msg_stored), 64'(0));
        check_tx(0, tx_header());
        for (i = 0; i < 5; i++) check_tx(i + 1, tx_words[i]);
        check("busy_pp2net_tx", 64'(busy_pp2net_tx), 64'(0));

        $display("all tests passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
qkd_bob_pkg.sv
fifo_if.sv
msg_ram.sv
er_fifo.sv
start_delay.sv
bob_unpacket.sv
bob_packet.sv
qkd_bob_top.sv
tb_qkd_bob.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and search the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_qkd_bob -f filelist.f -o tb_qkd_bob_sim
./obj_dir/tb_qkd_bob_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "all tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
